/* chipset_mem_req.sv */
`timescale 1ns/1ps
`include "mac_mem_params.svh"

module chipset_mem_req (
	input  logic                        rom_oe_n,
	input  logic                        ram_oe_n,
	input  logic                        ram_we_n,
	input  logic                        uds_n,
	input  logic                        lds_n,
	input  logic [`MAC_MEM_ADDR_W-1:0]  mem_addr,
	input  logic [`MAC_DATA_W-1:0]      mem_wdata,
	input  logic                        dsk_ack_int,
	input  logic                        dsk_ack_ext,
	input  logic                        model,
	output mac_mem_pkg::chip_req_t      chip
);
	import mac_mem_pkg::*;

	logic       dsk_rd;
	sdram_req_t req;

	// Either drive fetching a byte from its image
	assign dsk_rd = dsk_ack_int || dsk_ack_ext;

	// ========================================
	// Address map
	// ========================================

	always_comb begin
		if (!rom_oe_n) begin
			// ROM in the image area, Plus and SE images side by side
			req.addr = {`MAC_IMAGE_BASE, 2'b00, model, mem_addr[18:1]};
		end else begin
			// RAM at the bottom
			// disk reads go one step up into the extra-ROM area
			req.addr = {3'b000, dsk_rd, mem_addr[21:1]};
		end
	end

	// ========================================
	// Strobes
	// ========================================

	always_comb begin
		req.wdata = mem_wdata;
		// Upper byte on UDS, lower on LDS
		req.be    = {!uds_n, !lds_n};
		req.we    = !ram_we_n;
		// Any read source keeps the SDRAM read path open
		req.re    = !ram_oe_n || !rom_oe_n || dsk_rd;
	end

	// Bit 0 only matters to byte-wide disk reads
	assign chip = '{req: req, dsk_rd: dsk_rd, byte_sel: mem_addr[0]};

endmodule

/* mac_mem_params.svh */
`ifndef MAC_MEM_PARAMS_SVH
`define MAC_MEM_PARAMS_SVH

// ========================================
// Bus widths
// ========================================

// SDRAM word address, 32 Mword space
`define MAC_SDRAM_ADDR_W 25
// Chipset byte address from the address controller
`define MAC_MEM_ADDR_W 22
// Host download word address (byte address without bit 0)
`define MAC_DIO_ADDR_W 24
// Offset inside the ROM/download area
`define MAC_LOAD_ADDR_W 21
// Data word on every port
`define MAC_DATA_W 16
// Host download index
`define MAC_DL_INDEX_W 8

// ========================================
// Floppy images and memory map
// ========================================

// Image sizes in words, 800K and 400K disks
`define MAC_DSK_DS_WORDS 409600
`define MAC_DSK_SS_WORDS 204800

// Top prefix of ROM and download area, word address 0x200000
`define MAC_IMAGE_BASE 4'b0001

`endif

/* mac_mem_pkg.sv */
`include "mac_mem_params.svh"

package mac_mem_pkg;

	// ========================================
	// Memory requests
	// ========================================

	// One word request on the SDRAM port
	typedef struct packed {
		logic [`MAC_SDRAM_ADDR_W-1:0] addr;
		logic [`MAC_DATA_W-1:0]       wdata;
		// Byte enables, [1] upper and [0] lower
		logic [1:0]                   be;
		logic                         we;
		logic                         re;
	} sdram_req_t;

	// Word captured from the host, ready for its bus slot
	typedef struct packed {
		logic [`MAC_LOAD_ADDR_W-1:0] offset;
		// Already byte-swapped
		logic [`MAC_DATA_W-1:0]      data;
		logic                        wr;
	} load_req_t;

	// Chipset request plus what the read path needs
	typedef struct packed {
		sdram_req_t req;
		// Disk-read acknowledge from either drive
		logic       dsk_rd;
		// Chipset address bit 0, odd byte of a disk read
		logic       byte_sel;
	} chip_req_t;

	// Drive flags, index 0 internal and 1 external
	typedef struct packed {
		logic [1:0] inserted;
		logic [1:0] double_sided;
	} floppy_status_t;

	// ========================================
	// Enums
	// ========================================

	// Host word handshake
	typedef enum logic [1:0] {
		LD_IDLE,
		LD_PENDING,
		LD_ARMED
	} load_state_t;

	// Low two bits of the host index
	typedef enum logic [1:0] {
		DL_ROM        = 2'd0,
		DL_FLOPPY_INT = 2'd1,
		DL_FLOPPY_EXT = 2'd2
	} dl_index_t;

endpackage

/* mac_mem_top.sv */
`timescale 1ns/1ps
`include "mac_mem_params.svh"

module mac_mem_top (
	input  logic                           clk_sys,
	input  logic                           rst,
	// Host download port
	input  logic                           ioctl_download,
	input  logic [`MAC_DL_INDEX_W-1:0]     ioctl_index,
	input  logic                           ioctl_wr,
	input  logic [`MAC_DIO_ADDR_W:0]       ioctl_addr,
	input  logic [`MAC_DATA_W-1:0]         ioctl_data,
	output logic                           ioctl_wait,
	// Download slot of the bus cycle
	input  logic                           dio_slot,
	// Chipset strobes, active low
	input  logic                           rom_oe_n,
	input  logic                           ram_oe_n,
	input  logic                           ram_we_n,
	input  logic                           uds_n,
	input  logic                           lds_n,
	// Chipset addressing
	input  logic [`MAC_MEM_ADDR_W-1:0]     mem_addr,
	input  logic [`MAC_DATA_W-1:0]         mem_wdata,
	input  logic                           dsk_ack_int,
	input  logic                           dsk_ack_ext,
	input  logic                           model,
	// Floppy
	input  logic [1:0]                     disk_eject,
	output mac_mem_pkg::floppy_status_t    floppy,
	// SDRAM port
	input  logic [`MAC_DATA_W-1:0]         sdram_rdata,
	output mac_mem_pkg::sdram_req_t        sdram,
	// CPU read data
	output logic [`MAC_DATA_W-1:0]         cpu_rdata
);
	import mac_mem_pkg::*;

	load_req_t load;
	chip_req_t chip;

	// Host words and floppy flags
	mem_loader mem_loader_i (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.dio_slot       (dio_slot),
		.disk_eject     (disk_eject),
		.ioctl_wait     (ioctl_wait),
		.load           (load),
		.floppy         (floppy)
	);

	// Chipset side
	chipset_mem_req chipset_mem_req_i (
		.rom_oe_n    (rom_oe_n),
		.ram_oe_n    (ram_oe_n),
		.ram_we_n    (ram_we_n),
		.uds_n       (uds_n),
		.lds_n       (lds_n),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.dsk_ack_int (dsk_ack_int),
		.dsk_ack_ext (dsk_ack_ext),
		.model       (model),
		.chip        (chip)
	);

	// Single SDRAM port and CPU read path
	sdram_port_arbiter sdram_port_arbiter_i (
		.ioctl_download (ioctl_download),
		.dio_slot       (dio_slot),
		.load           (load),
		.chip           (chip),
		.sdram_rdata    (sdram_rdata),
		.sdram          (sdram),
		.cpu_rdata      (cpu_rdata)
	);

endmodule

/* mem_checker.sv */
`timescale 1ns/1ps
`include "mac_mem_params.svh"

module mem_checker (
	input  logic                           clk_sys,
	input  logic                           rst,
	input  logic                           ioctl_download,
	input  logic [`MAC_DL_INDEX_W-1:0]     ioctl_index,
	input  logic                           ioctl_wr,
	input  logic [`MAC_DIO_ADDR_W:0]       ioctl_addr,
	input  logic [`MAC_DATA_W-1:0]         ioctl_data,
	input  logic                           ioctl_wait,
	input  logic                           dio_slot,
	input  logic                           rom_oe_n,
	input  logic                           ram_oe_n,
	input  logic                           ram_we_n,
	input  logic                           uds_n,
	input  logic                           lds_n,
	input  logic [`MAC_MEM_ADDR_W-1:0]     mem_addr,
	input  logic [`MAC_DATA_W-1:0]         mem_wdata,
	input  logic                           dsk_ack_int,
	input  logic                           dsk_ack_ext,
	input  logic                           model,
	input  logic [1:0]                     disk_eject,
	input  mac_mem_pkg::floppy_status_t    floppy,
	input  logic [`MAC_DATA_W-1:0]         sdram_rdata,
	input  mac_mem_pkg::sdram_req_t        sdram,
	input  logic [`MAC_DATA_W-1:0]         cpu_rdata,
	output int                             error_count,
	output int                             check_count
);
	import mac_mem_pkg::*;

	// Handshake model
	logic                        pend = 1'b0;
	logic                        strobe = 1'b0;
	logic                        slot_prev = 1'b0;
	// Last captured host word
	logic                        loaded = 1'b0;
	logic [`MAC_LOAD_ADDR_W-1:0] m_offset;
	logic [`MAC_DATA_W-1:0]      m_data;
	// Floppy model
	logic                        down_prev;
	logic [1:0]                  idx_prev;
	logic [1:0]                  m_ins;
	logic [1:0]                  m_ds;

	task automatic expect_eq(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ========================================
	// Compare and step the model
	// ========================================

	// Sampled at the rising edge before the DUT registers update
	always @(posedge clk_sys) begin : compare_and_step
		sdram_req_t                 exp_req;
		logic                       dl_cyc;
		logic                       dsk;
		logic                       dl_end;
		logic [`MAC_DIO_ADDR_W-1:0] waddr;
		logic [`MAC_DATA_W-1:0]     exp_rd;
		if (rst) begin
			pend        = 1'b0;
			strobe      = 1'b0;
			slot_prev   = 1'b0;
			down_prev   = 1'b0;
			idx_prev    = 2'b00;
			m_ins       = 2'b00;
			m_ds        = 2'b00;
			error_count = 0;
			check_count = 0;
		end else begin
			dl_cyc = ioctl_download && dio_slot;
			dsk    = dsk_ack_int || dsk_ack_ext;
			waddr  = ioctl_addr[`MAC_DIO_ADDR_W:1];
			if (dl_cyc) begin
				// Loader word under the image base as a full word write
				exp_req.addr  = (25'(`MAC_IMAGE_BASE) << `MAC_LOAD_ADDR_W) + 25'(m_offset);
				exp_req.wdata = m_data;
				exp_req.be    = 2'b11;
				exp_req.we    = strobe;
				exp_req.re    = 1'b0;
				exp_rd        = 16'hffff;
			end else begin
				if (!rom_oe_n) begin
					exp_req.addr = (25'(`MAC_IMAGE_BASE) << `MAC_LOAD_ADDR_W)
						+ (25'(model) << 18) + 25'(mem_addr[18:1]);
				end else begin
					exp_req.addr = (25'(dsk) << 21) + 25'(mem_addr[21:1]);
				end
				exp_req.wdata = mem_wdata;
				exp_req.be    = {!uds_n, !lds_n};
				exp_req.we    = !ram_we_n;
				exp_req.re    = !rom_oe_n || !ram_oe_n || dsk;
				if (!dsk) begin
					exp_rd = sdram_rdata;
				end else if (mem_addr[0]) begin
					exp_rd = {2{sdram_rdata[7:0]}};
				end else begin
					exp_rd = {2{sdram_rdata[15:8]}};
				end
			end
			// Loader data is unknown until the first host word
			if (!dl_cyc || loaded) begin
				expect_eq("sdram.addr", 64'(sdram.addr), 64'(exp_req.addr));
				expect_eq("sdram.wdata", 64'(sdram.wdata), 64'(exp_req.wdata));
			end
			expect_eq("sdram.be", 64'(sdram.be), 64'(exp_req.be));
			expect_eq("sdram.we", 64'(sdram.we), 64'(exp_req.we));
			expect_eq("sdram.re", 64'(sdram.re), 64'(exp_req.re));
			expect_eq("cpu_rdata", 64'(cpu_rdata), 64'(exp_rd));
			expect_eq("ioctl_wait", 64'(ioctl_wait), 64'(pend || strobe));
			expect_eq("floppy", 64'(floppy), 64'({m_ins, m_ds}));

			// Wait level holds a pending word and then the strobe until the slot falls
			if (strobe) begin
				if (slot_prev && !dio_slot) begin
					strobe = 1'b0;
				end
			end else if (pend) begin
				if (!dio_slot) begin
					pend   = 1'b0;
					strobe = 1'b1;
				end
			end else if (ioctl_wr) begin
				pend = 1'b1;
			end
			slot_prev = dio_slot;

			if (ioctl_wr) begin
				loaded = 1'b1;
				m_data = {ioctl_data[7:0], ioctl_data[15:8]};
				if (ioctl_index[1:0] == 2'b00) begin
					m_offset = (21'(ioctl_index[6]) << 18) + 21'(waddr[17:0]);
				end else begin
					m_offset = (21'(ioctl_index[1:0]) << 19) + 21'(waddr[18:0]);
				end
			end

			// Image size from the final word address
			// Eject wins over a download end
			dl_end = down_prev && !ioctl_download;
			for (int d = 0; d < 2; d++) begin
				if (disk_eject[d]) begin
					m_ins[d] = 1'b0;
					m_ds[d]  = 1'b0;
				end else if (dl_end && idx_prev == 2'(d + 1)) begin
					m_ds[d]  = (waddr == `MAC_DSK_DS_WORDS);
					m_ins[d] = (waddr == `MAC_DSK_DS_WORDS) || (waddr == `MAC_DSK_SS_WORDS);
				end
			end
			down_prev = ioctl_download;
			idx_prev  = ioctl_index[1:0];
		end
	end

endmodule

/* mem_loader.sv */
`timescale 1ns/1ps
`include "mac_mem_params.svh"

module mem_loader (
	input  logic                           clk_sys,
	input  logic                           rst,
	input  logic                           ioctl_download,
	input  logic [`MAC_DL_INDEX_W-1:0]     ioctl_index,
	input  logic                           ioctl_wr,
	input  logic [`MAC_DIO_ADDR_W:0]       ioctl_addr,
	input  logic [`MAC_DATA_W-1:0]         ioctl_data,
	input  logic                           dio_slot,
	input  logic [1:0]                     disk_eject,
	output logic                           ioctl_wait,
	output mac_mem_pkg::load_req_t         load,
	output mac_mem_pkg::floppy_status_t    floppy
);
	import mac_mem_pkg::*;

	// Host word address and target
	logic [`MAC_DIO_ADDR_W-1:0]  dio_addr;
	dl_index_t                   dl_idx;

	// Captured word
	logic [`MAC_LOAD_ADDR_W-1:0] load_offset;
	logic [`MAC_DATA_W-1:0]      load_data;

	// Handshake
	load_state_t                 state;
	logic                        slot_q;

	// Floppy detection
	logic                        down_q;
	dl_index_t                   index_q;
	logic                        dl_end;
	logic [1:0]                  drive_hit;
	logic                        is_ds;
	logic                        is_ss;
	logic [1:0]                  ins_q;
	logic [1:0]                  ds_q;

	assign dio_addr = ioctl_addr[`MAC_DIO_ADDR_W:1];
	assign dl_idx   = dl_index_t'(ioctl_index[1:0]);

	// ========================================
	// Word capture
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			// Host sends little-endian words, the 68000 wants big-endian
			load_data <= {ioctl_data[7:0], ioctl_data[15:8]};
			// ROM halves sit below the two floppy areas
			if (dl_idx == DL_ROM) begin
				load_offset <= {2'b00, ioctl_index[6], dio_addr[17:0]};
			end else begin
				load_offset <= {ioctl_index[1:0], dio_addr[18:0]};
			end
		end
	end

	// ========================================
	// Wait handshake
	// ========================================

	// PENDING until a low slot arms the strobe
	// ARMED through the next high slot, released when it falls
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state  <= LD_IDLE;
			slot_q <= 1'b0;
		end else begin
			slot_q <= dio_slot;
			case (state)
				LD_IDLE: begin
					if (ioctl_wr) begin
						state <= LD_PENDING;
					end
				end
				LD_PENDING: begin
					if (!dio_slot) begin
						state <= LD_ARMED;
					end
				end
				LD_ARMED: begin
					// Slot just ended, so the word has been written
					if (slot_q && !dio_slot) begin
						state <= LD_IDLE;
					end
				end
				default: begin
					state <= LD_IDLE;
				end
			endcase
		end
	end

	assign ioctl_wait = (state != LD_IDLE);
	assign load       = '{offset: load_offset, data: load_data, wr: (state == LD_ARMED)};

	// ========================================
	// Floppy image detection
	// ========================================

	// Download end, final word address gives the image size
	assign dl_end    = down_q && !ioctl_download;
	assign drive_hit = {index_q == DL_FLOPPY_EXT, index_q == DL_FLOPPY_INT};
	assign is_ds     = (dio_addr == `MAC_DSK_DS_WORDS);
	assign is_ss     = (dio_addr == `MAC_DSK_SS_WORDS);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			down_q  <= 1'b0;
			index_q <= DL_ROM;
			ins_q   <= '0;
			ds_q    <= '0;
		end else begin
			down_q  <= ioctl_download;
			index_q <= dl_idx;
			for (int d = 0; d < 2; d++) begin
				// Eject beats a download ending on the same edge
				if (disk_eject[d]) begin
					ins_q[d] <= 1'b0;
					ds_q[d]  <= 1'b0;
				end else if (dl_end && drive_hit[d]) begin
					ds_q[d]  <= is_ds;
					ins_q[d] <= is_ds || is_ss;
				end
			end
		end
	end

	assign floppy = '{inserted: ins_q, double_sided: ds_q};

endmodule

/* sdram_port_arbiter.sv */
`timescale 1ns/1ps
`include "mac_mem_params.svh"

module sdram_port_arbiter (
	input  logic                        ioctl_download,
	input  logic                        dio_slot,
	input  mac_mem_pkg::load_req_t      load,
	input  mac_mem_pkg::chip_req_t      chip,
	input  logic [`MAC_DATA_W-1:0]      sdram_rdata,
	output mac_mem_pkg::sdram_req_t     sdram,
	output logic [`MAC_DATA_W-1:0]      cpu_rdata
);
	import mac_mem_pkg::*;

	logic                   dl_cycle;
	sdram_req_t             dl_req;
	logic [`MAC_DATA_W-1:0] dsk_data;

	// Loader owns the port only in the download slot of a download
	assign dl_cycle = ioctl_download && dio_slot;

	// ========================================
	// Request select
	// ========================================

	always_comb begin
		// Loader offset sits under the image base
		dl_req.addr  = {`MAC_IMAGE_BASE, load.offset};
		dl_req.wdata = load.data;
		// Full words only
		dl_req.be    = 2'b11;
		dl_req.we    = load.wr;
		dl_req.re    = 1'b0;
	end

	assign sdram = dl_cycle ? dl_req : chip.req;

	// ========================================
	// Read data steering
	// ========================================

	// Disk image is byte-wide
	// odd address takes the low byte, even the high byte
	always_comb begin
		if (chip.byte_sel) begin
			dsk_data = {sdram_rdata[7:0], sdram_rdata[7:0]};
		end else begin
			dsk_data = {sdram_rdata[15:8], sdram_rdata[15:8]};
		end
	end

	always_comb begin
		if (dl_cycle) begin
			// All ones during download, screen stays black
			cpu_rdata = '1;
		end else if (chip.dsk_rd) begin
			cpu_rdata = dsk_data;
		end else begin
			cpu_rdata = sdram_rdata;
		end
	end

endmodule

/* tb.f */
+incdir+.
mac_mem_pkg.sv
mem_loader.sv
chipset_mem_req.sv
sdram_port_arbiter.sv
mac_mem_top.sv
mem_checker.sv
tb_mac_mem.sv

/* tb_mac_mem.sv */
`timescale 1ns/1ps
`include "mac_mem_params.svh"

module tb_mac_mem;
	import mac_mem_pkg::*;

	// Host words per download
	// First half at the image start and the rest at its end
	localparam int WORDS_PER_DL    = 8;
	localparam int NUM_DL          = 7;
	localparam int CHIP_CYCLES     = 200;
	localparam int WATCHDOG_CYCLES = NUM_DL * WORDS_PER_DL * 20 + 2000;

	logic                          clk_sys = 1'b0;
	logic                          rst = 1'b1;
	logic                          ioctl_download = 1'b0;
	logic [`MAC_DL_INDEX_W-1:0]    ioctl_index = '0;
	logic                          ioctl_wr = 1'b0;
	logic [`MAC_DIO_ADDR_W:0]      ioctl_addr = '0;
	logic [`MAC_DATA_W-1:0]        ioctl_data = '0;
	logic                          ioctl_wait;
	logic                          dio_slot = 1'b0;
	logic                          rom_oe_n = 1'b1;
	logic                          ram_oe_n = 1'b1;
	logic                          ram_we_n = 1'b1;
	logic                          uds_n = 1'b1;
	logic                          lds_n = 1'b1;
	logic [`MAC_MEM_ADDR_W-1:0]    mem_addr = '0;
	logic [`MAC_DATA_W-1:0]        mem_wdata = '0;
	logic                          dsk_ack_int = 1'b0;
	logic                          dsk_ack_ext = 1'b0;
	logic                          model = 1'b0;
	logic [1:0]                    disk_eject = 2'b00;
	logic [`MAC_DATA_W-1:0]        sdram_rdata = '0;
	floppy_status_t                floppy;
	sdram_req_t                    sdram;
	logic [`MAC_DATA_W-1:0]        cpu_rdata;
	int                            error_count;
	int                            check_count;
	int                            slot_left = 1;

	always #50 clk_sys = !clk_sys;

	mac_mem_top mac_mem_top_i (
		.clk_sys(clk_sys), .rst(rst),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.ioctl_wait(ioctl_wait), .dio_slot(dio_slot),
		.rom_oe_n(rom_oe_n), .ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n),
		.uds_n(uds_n), .lds_n(lds_n), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.dsk_ack_int(dsk_ack_int), .dsk_ack_ext(dsk_ack_ext), .model(model),
		.disk_eject(disk_eject), .floppy(floppy),
		.sdram_rdata(sdram_rdata), .sdram(sdram), .cpu_rdata(cpu_rdata)
	);

	mem_checker mem_checker_i (
		.clk_sys(clk_sys), .rst(rst),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.ioctl_wait(ioctl_wait), .dio_slot(dio_slot),
		.rom_oe_n(rom_oe_n), .ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n),
		.uds_n(uds_n), .lds_n(lds_n), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.dsk_ack_int(dsk_ack_int), .dsk_ack_ext(dsk_ack_ext), .model(model),
		.disk_eject(disk_eject), .floppy(floppy),
		.sdram_rdata(sdram_rdata), .sdram(sdram), .cpu_rdata(cpu_rdata),
		.error_count(error_count), .check_count(check_count)
	);

	// ========================================
	// Random chipset side and bus slot
	// ========================================

	always @(negedge clk_sys) begin : chipset_stim
		logic [31:0] rnd;
		rnd         = $urandom;
		rom_oe_n    = rnd[0];
		ram_oe_n    = rnd[1];
		ram_we_n    = rnd[2];
		uds_n       = rnd[3];
		lds_n       = rnd[4];
		model       = rnd[5];
		// Disk acks about one cycle in four
		dsk_ack_int = (rnd[7:6] == 2'b00);
		dsk_ack_ext = (rnd[9:8] == 2'b00);
		mem_addr    = rnd[31:10];
		rnd         = $urandom;
		mem_wdata   = rnd[15:0];
		sdram_rdata = rnd[31:16];
		// Slot phases of 1 to 3 cycles give a period of 2 to 6
		if (slot_left == 0) begin
			dio_slot  = !dio_slot;
			slot_left = $urandom_range(1, 3);
		end
		slot_left = slot_left - 1;
	end

	// ========================================
	// Host download port
	// ========================================

	// One word held off by the wait level
	task automatic send_word(input logic [`MAC_DIO_ADDR_W:0] byte_addr,
			input logic [`MAC_DATA_W-1:0] data);
		while (ioctl_wait) begin
			@(negedge clk_sys);
		end
		ioctl_addr = byte_addr;
		ioctl_data = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		while (ioctl_wait) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic run_download(input logic [7:0] index, input int unsigned words,
			input logic [1:0] eject);
		int unsigned waddr;
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < WORDS_PER_DL; i++) begin
			if (i < WORDS_PER_DL / 2) begin
				waddr = i;
			end else begin
				waddr = words - WORDS_PER_DL + i;
			end
			send_word(25'(waddr * 2), 16'($urandom));
		end
		// Host leaves the byte count on the address at the end
		ioctl_addr     = 25'(words * 2);
		ioctl_download = 1'b0;
		disk_eject     = eject;
		@(negedge clk_sys);
		disk_eject = 2'b00;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic pulse_eject(input logic [1:0] drives);
		disk_eject = drives;
		@(negedge clk_sys);
		disk_eject = 2'b00;
		repeat (2) @(negedge clk_sys);
	endtask

	// ========================================
	// Sequence
	// ========================================

	initial begin : main_seq
		int unsigned seed;
		int unsigned other_len;
		seed = 32'ha67d;
		void'($urandom(seed));
		repeat (2) @(negedge clk_sys);
		rst = 1'b0;
		repeat (CHIP_CYCLES) @(negedge clk_sys);
		// ROM halves
		// Addresses past 2^18 wrap inside the half
		run_download(8'h00, 300000, 2'b00);
		run_download(8'h40, 300000, 2'b00);
		// Floppy images by size
		run_download(8'h01, `MAC_DSK_DS_WORDS, 2'b00);
		run_download(8'h02, `MAC_DSK_SS_WORDS, 2'b00);
		pulse_eject(2'b01);
		other_len = $urandom_range(1000, 200000);
		run_download(8'h02, other_len, 2'b00);
		run_download(8'h01, `MAC_DSK_DS_WORDS, 2'b00);
		// Eject lands on the edge that sees the download end
		run_download(8'h02, `MAC_DSK_DS_WORDS, 2'b10);
		repeat (CHIP_CYCLES) @(negedge clk_sys);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES + 2 * CHIP_CYCLES) @(posedge clk_sys);
		$display("Timeout: the downloads did not complete in the expected number of cycles");
		$display("Test failed");
		$finish;
	end

endmodule
